// File: hw/soc_bus_pkg.sv
package soc_bus_pkg;

    // bus side types
    typedef logic [15:0] addr_t;  // byte address, covers the whole map
    typedef logic [63:0] data_t;
    typedef logic [31:0] word_t;  // one memory word

    // word memory region, rom and ram merged
    localparam addr_t MEM_BASE  = 16'h0000;
    localparam int    MEM_WORDS = 1024;
    localparam int    MEM_BYTES = MEM_WORDS * 4;
    localparam int    MEM_IDX_W = $clog2(MEM_WORDS);

    // sd sector window, byte wide
    localparam addr_t SEC_BASE  = 16'h2000;
    localparam int    SEC_BYTES = 512;
    localparam int    SEC_IDX_W = $clog2(SEC_BYTES);

    // single address registers
    localparam addr_t KEY_ADDR      = 16'h3000;
    localparam addr_t SD_ADDR_ADDR  = 16'h3008;
    localparam addr_t SD_READ_ADDR  = 16'h3010;
    localparam addr_t SD_READY_ADDR = 16'h3018;
    localparam addr_t SD_AVAIL_ADDR = 16'h3020;

    // register write select, sequencer to io_regs
    localparam logic [1:0] REG_SD_SECTOR = 2'd1;
    localparam logic [1:0] REG_SD_READ   = 2'd2;

    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_HALF,
        SZ_WORD,
        SZ_DOUBLE  // two words, low word at the lower address
    } size_e;

    // decoded target of a request
    typedef enum logic [2:0] {
        RGN_NONE,  // unmapped
        RGN_MEM,
        RGN_SEC,
        RGN_KEY,
        RGN_SD_ADDR,
        RGN_SD_READ,
        RGN_READY,
        RGN_AVAIL
    } region_e;

    typedef struct packed {
        logic  wr;     // 1 = store
        size_e size;
        addr_t addr;
        data_t wdata;
    } bus_req_t;

    typedef struct packed {
        data_t data;
        logic  err;    // unmapped address
    } bus_rsp_t;

    typedef struct packed {
        logic [MEM_IDX_W-1:0] idx;
        logic                 we;
        logic [3:0]           mask;  // byte lanes, bit 0 = bits 7:0
        word_t                wdata;
    } ram_cmd_t;

endpackage

// File: hw/bus_sequencer.sv
`timescale 1ns/1ps

module bus_sequencer (
    input  logic                              CLOCK_50,
    input  logic                              KEY0,
    input  logic                              req_valid,
    input  soc_bus_pkg::bus_req_t             bus_req,
    input  soc_bus_pkg::word_t                ram_rdata,
    input  logic [7:0]                        sec_rdata,
    input  logic [7:0]                        key_code,
    input  logic                              sector_avail,
    input  logic                              sd_ready,
    output logic                              req_ready,
    output logic                              done,
    output soc_bus_pkg::bus_rsp_t             bus_rsp,
    output soc_bus_pkg::ram_cmd_t             ram_cmd,
    output logic [soc_bus_pkg::SEC_IDX_W-1:0] sec_index,
    output logic                              reg_wr,
    output logic [1:0]                        reg_sel,
    output logic [31:0]                       reg_wdata
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FIRST,   // first ram word or sector byte in flight
        S_SECOND,  // second word of a double
        S_RESP
    } state_e;

    state_e                               state;
    soc_bus_pkg::bus_req_t                req_q;
    soc_bus_pkg::region_e                 rgn_q;
    soc_bus_pkg::region_e                 rgn_in;
    soc_bus_pkg::addr_t                   mem_off;
    soc_bus_pkg::addr_t                   sec_off;
    soc_bus_pkg::word_t                   lo_word;  // low half of a double load
    soc_bus_pkg::word_t                   lane_data;
    soc_bus_pkg::word_t                   ram_wdata;
    soc_bus_pkg::bus_rsp_t                rsp_next;
    logic [soc_bus_pkg::MEM_IDX_W-1:0]    ram_idx;
    logic [3:0]                           lane_mask;
    logic [3:0]                           ram_mask;
    logic                                 ram_we;
    logic                                 accept;
    logic                                 is_double;

    assign req_ready = (state == S_IDLE) && !done;  // stays low through the done cycle
    assign accept    = req_valid && req_ready;
    assign is_double = (rgn_q == soc_bus_pkg::RGN_MEM) && (req_q.size == soc_bus_pkg::SZ_DOUBLE);

    // address decode straight off the request
    always_comb begin
        mem_off = bus_req.addr - soc_bus_pkg::MEM_BASE;
        sec_off = bus_req.addr - soc_bus_pkg::SEC_BASE;
        rgn_in  = soc_bus_pkg::RGN_NONE;
        if (mem_off < soc_bus_pkg::MEM_BYTES) begin
            rgn_in = soc_bus_pkg::RGN_MEM;
        end else if (sec_off < soc_bus_pkg::SEC_BYTES) begin
            rgn_in = soc_bus_pkg::RGN_SEC;
        end else begin
            case (bus_req.addr)
                soc_bus_pkg::KEY_ADDR:      rgn_in = soc_bus_pkg::RGN_KEY;
                soc_bus_pkg::SD_ADDR_ADDR:  rgn_in = soc_bus_pkg::RGN_SD_ADDR;
                soc_bus_pkg::SD_READ_ADDR:  rgn_in = soc_bus_pkg::RGN_SD_READ;
                soc_bus_pkg::SD_READY_ADDR: rgn_in = soc_bus_pkg::RGN_READY;
                soc_bus_pkg::SD_AVAIL_ADDR: rgn_in = soc_bus_pkg::RGN_AVAIL;
                default:                    rgn_in = soc_bus_pkg::RGN_NONE;
            endcase
        end
    end

    // store lanes, data moved up to the addressed byte
    always_comb begin
        case (bus_req.size)
            soc_bus_pkg::SZ_BYTE: begin
                lane_mask = 4'b0001 << bus_req.addr[1:0];
                lane_data = 32'(bus_req.wdata[7:0]) << {bus_req.addr[1:0], 3'b000};
            end
            soc_bus_pkg::SZ_HALF: begin
                lane_mask = 4'b0011 << bus_req.addr[1:0];  // offset 3 loses the top byte
                lane_data = 32'(bus_req.wdata[15:0]) << {bus_req.addr[1:0], 3'b000};
            end
            default: begin
                lane_mask = 4'b1111;  // word and low half of double
                lane_data = bus_req.wdata[31:0];
            end
        endcase
    end

    // load formatting, zero extended
    always_comb begin
        rsp_next.err  = (rgn_q == soc_bus_pkg::RGN_NONE);
        rsp_next.data = '0;
        if (!req_q.wr) begin
            case (rgn_q)
                soc_bus_pkg::RGN_MEM: begin
                    if (req_q.size == soc_bus_pkg::SZ_DOUBLE) begin
                        rsp_next.data = {ram_rdata, lo_word};
                    end else begin
                        rsp_next.data = 64'(ram_rdata >> {req_q.addr[1:0], 3'b000});
                    end
                end
                soc_bus_pkg::RGN_SEC:   rsp_next.data = 64'(sec_rdata);  // one byte, any size
                soc_bus_pkg::RGN_KEY:   rsp_next.data = 64'(key_code);
                soc_bus_pkg::RGN_READY: rsp_next.data = 64'(sd_ready);
                soc_bus_pkg::RGN_AVAIL: rsp_next.data = 64'(sector_avail);
                default:                rsp_next.data = '0;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state  <= S_IDLE;
            done   <= 1'b0;
            reg_wr <= 1'b0;
            ram_we <= 1'b0;
        end else begin
            done   <= 1'b0;  // all single cycle strobes
            reg_wr <= 1'b0;
            ram_we <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        if (rgn_in == soc_bus_pkg::RGN_MEM || rgn_in == soc_bus_pkg::RGN_SEC) begin
                            state <= S_FIRST;
                        end else begin
                            state <= S_RESP;  // registers answer next edge
                        end
                        ram_we <= bus_req.wr && (rgn_in == soc_bus_pkg::RGN_MEM);
                        reg_wr <= bus_req.wr && (rgn_in == soc_bus_pkg::RGN_SD_ADDR ||
                                                 rgn_in == soc_bus_pkg::RGN_SD_READ);
                    end
                end
                S_FIRST: begin
                    if (is_double) begin
                        state  <= S_SECOND;
                        ram_we <= req_q.wr;  // upper word store
                    end else begin
                        state <= S_RESP;
                    end
                end
                S_SECOND: state <= S_RESP;
                default: begin
                    state <= S_IDLE;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    // request copy and memory command payload
    always_ff @(posedge CLOCK_50) begin
        case (state)
            S_IDLE: begin
                if (accept) begin
                    req_q     <= bus_req;
                    rgn_q     <= rgn_in;
                    ram_idx   <= mem_off[soc_bus_pkg::MEM_IDX_W+1:2];
                    ram_mask  <= lane_mask;
                    ram_wdata <= lane_data;
                    sec_index <= sec_off[soc_bus_pkg::SEC_IDX_W-1:0];
                end
            end
            S_FIRST: begin
                ram_idx   <= ram_idx + 1'b1;  // next word, only used by doubles
                ram_mask  <= 4'b1111;
                ram_wdata <= req_q.wdata[63:32];
            end
            S_SECOND: lo_word <= ram_rdata;  // first word back now
            default: bus_rsp <= rsp_next;
        endcase
    end

    assign ram_cmd   = '{idx: ram_idx, we: ram_we, mask: ram_mask, wdata: ram_wdata};
    assign reg_sel   = (rgn_q == soc_bus_pkg::RGN_SD_READ) ? soc_bus_pkg::REG_SD_READ
                                                          : soc_bus_pkg::REG_SD_SECTOR;
    assign reg_wdata = req_q.wdata[31:0];

endmodule

// File: hw/sector_counter.sv
`timescale 1ns/1ps

module sector_counter (
    input  logic                              CLOCK_50,
    input  logic                              KEY0,
    input  logic                              sd_byte_valid,
    output logic [soc_bus_pkg::SEC_IDX_W-1:0] wr_index,
    output logic                              wr_en,
    output logic                              sector_avail
);

    // every stream byte lands at the current index
    assign wr_en = sd_byte_valid;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_index     <= '0;
            sector_avail <= 1'b0;
        end else if (sd_byte_valid) begin
            wr_index <= wr_index + 1'b1;  // wraps at SEC_BYTES, power of two
            if (&wr_index) begin
                sector_avail <= 1'b1;  // byte 511 just written
            end else if (wr_index == '0) begin
                // new fill started, old contents going away
                sector_avail <= 1'b0;
            end
        end
    end

endmodule

// File: hw/word_ram.sv
`timescale 1ns/1ps

module word_ram (
    input  logic                  CLOCK_50,
    input  soc_bus_pkg::ram_cmd_t ram_cmd,
    output soc_bus_pkg::word_t    rdata
);

    // rom and ram share this array
    soc_bus_pkg::word_t mem [soc_bus_pkg::MEM_WORDS];

    always_ff @(posedge CLOCK_50) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (ram_cmd.we && ram_cmd.mask[lane]) begin
                mem[ram_cmd.idx][8*lane +: 8] <= ram_cmd.wdata[8*lane +: 8];  // masked lane
            end
        end
        // read before write, old word on a same-cycle store
        rdata <= mem[ram_cmd.idx];
    end

endmodule

// File: hw/sector_buffer.sv
`timescale 1ns/1ps

module sector_buffer (
    input  logic                              CLOCK_50,
    input  logic                              wr_en,
    input  logic [soc_bus_pkg::SEC_IDX_W-1:0] wr_index,
    input  logic [7:0]                        wr_byte,
    input  logic [soc_bus_pkg::SEC_IDX_W-1:0] rd_index,
    output logic [7:0]                        rd_byte
);

    logic [7:0] store [soc_bus_pkg::SEC_BYTES];  // one sd sector

    // stream side
    always_ff @(posedge CLOCK_50) begin
        if (wr_en) begin
            store[wr_index] <= wr_byte;
        end
    end

    // bus side, one cycle latency
    always_ff @(posedge CLOCK_50) begin
        rd_byte <= store[rd_index];
    end

endmodule

// File: hw/io_regs.sv
`timescale 1ns/1ps

module io_regs (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        key_strobe,
    input  logic [7:0]  key_ascii,
    input  logic        irq_ack,
    input  logic        reg_wr,
    input  logic [1:0]  reg_sel,
    input  logic [31:0] reg_wdata,
    output logic [7:0]  key_code,
    output logic        irq,
    output logic [31:0] sd_sector,
    output logic        sd_rd_start
);

    // keyboard latch and interrupt
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_code <= 8'd0;
            irq      <= 1'b0;
        end else begin
            if (key_strobe) begin
                key_code <= key_ascii;  // last key, also zero codes
            end
            if (key_strobe && key_ascii != 8'd0) begin
                irq <= 1'b1;  // new key wins over a same-cycle ack
            end else if (irq_ack) begin
                irq <= 1'b0;
            end
        end
    end

    // sd sector address and read trigger
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_sector   <= 32'd0;
            sd_rd_start <= 1'b0;
        end else begin
            sd_rd_start <= reg_wr && (reg_sel == soc_bus_pkg::REG_SD_READ);  // one cycle
            if (reg_wr && reg_sel == soc_bus_pkg::REG_SD_SECTOR) begin
                sd_sector <= reg_wdata;
            end
        end
    end

endmodule

// File: hw/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  req_valid,
    input  soc_bus_pkg::bus_req_t bus_req,
    input  logic                  key_strobe,
    input  logic [7:0]            key_ascii,
    input  logic                  irq_ack,
    input  logic                  sd_byte_valid,
    input  logic [7:0]            sd_byte,
    input  logic                  sd_ready,
    output logic                  req_ready,
    output logic                  done,
    output soc_bus_pkg::bus_rsp_t bus_rsp,
    output logic                  irq,
    output logic [31:0]           sd_sector,
    output logic                  sd_rd_start,
    output logic                  sector_avail
);

    soc_bus_pkg::ram_cmd_t             ram_cmd;
    soc_bus_pkg::word_t                ram_rdata;
    logic [soc_bus_pkg::SEC_IDX_W-1:0] sec_index;   // bus read side
    logic [soc_bus_pkg::SEC_IDX_W-1:0] sec_wr_index;  // stream write side
    logic                              sec_wr_en;
    logic [7:0]                        sec_rdata;
    logic [7:0]                        key_code;
    logic                              reg_wr;
    logic [1:0]                        reg_sel;
    logic [31:0]                       reg_wdata;

    bus_sequencer u_seq (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .req_valid    (req_valid),
        .bus_req      (bus_req),
        .ram_rdata    (ram_rdata),
        .sec_rdata    (sec_rdata),
        .key_code     (key_code),
        .sector_avail (sector_avail),
        .sd_ready     (sd_ready),
        .req_ready    (req_ready),
        .done         (done),
        .bus_rsp      (bus_rsp),
        .ram_cmd      (ram_cmd),
        .sec_index    (sec_index),
        .reg_wr       (reg_wr),
        .reg_sel      (reg_sel),
        .reg_wdata    (reg_wdata)
    );

    sector_counter u_cnt (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .sd_byte_valid (sd_byte_valid),
        .wr_index      (sec_wr_index),
        .wr_en         (sec_wr_en),
        .sector_avail  (sector_avail)
    );

    word_ram u_ram (
        .CLOCK_50 (CLOCK_50),
        .ram_cmd  (ram_cmd),
        .rdata    (ram_rdata)
    );

    sector_buffer u_sec (
        .CLOCK_50 (CLOCK_50),
        .wr_en    (sec_wr_en),
        .wr_index (sec_wr_index),
        .wr_byte  (sd_byte),
        .rd_index (sec_index),
        .rd_byte  (sec_rdata)
    );

    io_regs u_io (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_strobe  (key_strobe),
        .key_ascii   (key_ascii),
        .irq_ack     (irq_ack),
        .reg_wr      (reg_wr),
        .reg_sel     (reg_sel),
        .reg_wdata   (reg_wdata),
        .key_code    (key_code),
        .irq         (irq),
        .sd_sector   (sd_sector),
        .sd_rd_start (sd_rd_start)
    );

endmodule

// File: tests/soc_bus_asserts.sv
`timescale 1ns/1ps

module soc_bus_asserts (
    input logic CLOCK_50,
    input logic KEY0,
    input logic req_valid,
    input logic req_ready,
    input logic done,
    input logic sd_rd_start
);

    // master may only ask while the sequencer is idle
    valid_while_busy: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(req_valid && !req_ready))
        else $error("req_valid high while req_ready low");

    done_one_cycle: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        done |=> !done)
        else $error("done held for more than one cycle");

    // read trigger is a single pulse
    start_one_cycle: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start |=> !sd_rd_start)
        else $error("sd_rd_start high for two cycles in a row");

endmodule

// top level holds all three signals
bind soc_bus_top soc_bus_asserts u_asserts (.*);

// File: tests/bus_checker.sv
`timescale 1ns/1ps

module bus_checker (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  req_valid,
    input  logic                  req_ready,
    input  logic                  done,
    input  soc_bus_pkg::bus_rsp_t bus_rsp,
    input  logic                  irq,
    input  logic [31:0]           sd_sector,
    input  logic                  sd_rd_start,
    input  logic                  sector_avail,
    input  logic [8*12-1:0]       exp_name,    // entry name, ascii packed
    input  soc_bus_pkg::data_t    exp_data,
    input  logic                  exp_err,
    input  logic                  exp_irq,
    input  logic                  exp_avail,
    input  logic [31:0]           exp_sector,
    input  logic                  exp_start,   // read trigger due in the done cycle
    output int                    errors
);

    int   err_count = 0;
    logic busy      = 1'b0;  // accepted, done not seen yet

    assign errors = err_count;

    task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            err_count++;
            $display("mismatch %0s %0s: expected %h, actual %h", exp_name, what, exp, act);
        end
    endtask

    // sampled on the edge, values are the settled ones from the cycle before
    always @(posedge CLOCK_50) begin
        if (KEY0 && done) begin
            compare("data", exp_data, bus_rsp.data);
            compare("err", 64'(exp_err), 64'(bus_rsp.err));
            compare("irq", 64'(exp_irq), 64'(irq));
            compare("avail", 64'(exp_avail), 64'(sector_avail));
            compare("sector", 64'(exp_sector), 64'(sd_sector));
            compare("rd_start", 64'(exp_start), 64'(sd_rd_start));
        end
        if (KEY0 && sd_rd_start && !done) begin
            err_count++;
            $display("sd_rd_start pulsed outside a done cycle");  // stray trigger
        end
        // ready must stay low from acceptance through the done cycle
        if (KEY0 && busy && req_ready) begin
            err_count++;
            $display("req_ready high while a request was still in flight");
        end
        if (!KEY0 || done) begin
            busy <= 1'b0;
        end else if (req_valid && req_ready) begin
            busy <= 1'b1;
        end
    end

endmodule

// File: tests/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;

    typedef struct {
        logic [8*12-1:0]       name;
        int                    ev;   // 0 none 1 key 2 ack 3 full fill 4 one byte 5 ready
        logic [7:0]            arg;  // key code or sd_ready level
        soc_bus_pkg::bus_req_t req;
        soc_bus_pkg::data_t    exp;  // ignored for sector reads
        logic                  err;
    } entry_t;

    logic                  CLOCK_50 = 1'b0;
    logic                  KEY0;
    logic                  req_valid;
    soc_bus_pkg::bus_req_t bus_req;
    logic                  key_strobe;
    logic [7:0]            key_ascii;
    logic                  irq_ack;
    logic                  sd_byte_valid;
    logic [7:0]            sd_byte;
    logic                  sd_ready;
    logic                  req_ready;
    logic                  done;
    soc_bus_pkg::bus_rsp_t bus_rsp;
    logic                  irq;
    logic [31:0]           sd_sector;
    logic                  sd_rd_start;
    logic                  sector_avail;

    logic [8*12-1:0]       exp_name;
    soc_bus_pkg::data_t    exp_data;
    logic                  exp_err;
    logic                  exp_irq;
    logic                  exp_avail;
    logic [31:0]           exp_sector;
    logic                  exp_start;
    int                    check_errors;

    entry_t      tbl[$];
    logic [7:0]  rec [soc_bus_pkg::SEC_BYTES];  // bytes as streamed
    int          stream_idx;
    int          cycles = 0;
    int          limit = 0;
    logic        m_irq;     // expected side outputs
    logic        m_avail;
    logic [31:0] m_sector;

    always #2 CLOCK_50 = ~CLOCK_50;  // 4 ns period

    soc_bus_top DUT (.*);

    bus_checker chk (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0), .req_valid(req_valid), .req_ready(req_ready),
        .done(done), .bus_rsp(bus_rsp), .irq(irq),
        .sd_sector(sd_sector), .sd_rd_start(sd_rd_start), .sector_avail(sector_avail),
        .exp_name(exp_name), .exp_data(exp_data), .exp_err(exp_err), .exp_irq(exp_irq),
        .exp_avail(exp_avail), .exp_sector(exp_sector), .exp_start(exp_start),
        .errors(check_errors)
    );

    task automatic add_entry(input logic [8*12-1:0] nm, input int ev, input logic [7:0] arg,
                             input logic wr, input int sz, input logic [15:0] addr,
                             input logic [63:0] wdata, input logic [63:0] exp, input logic err);
        entry_t e;
        e.name      = nm;
        e.ev        = ev;
        e.arg       = arg;
        e.req.wr    = wr;
        e.req.size  = soc_bus_pkg::size_e'(sz);
        e.req.addr  = addr;
        e.req.wdata = wdata;
        e.exp       = exp;
        e.err       = err;
        tbl.push_back(e);
    endtask

    // one byte, then an idle cycle
    task automatic stream_byte();
        logic [7:0] b;
        b = 8'($urandom);
        rec[stream_idx] = b;
        stream_idx = (stream_idx + 1) % soc_bus_pkg::SEC_BYTES;
        sd_byte_valid <= 1'b1;
        sd_byte       <= b;
        @(posedge CLOCK_50);
        sd_byte_valid <= 1'b0;
        @(posedge CLOCK_50);
    endtask

    task automatic run_entry(input entry_t e);
        soc_bus_pkg::data_t exp_val;
        int off;
        case (e.ev)
            1: begin
                key_strobe <= 1'b1;
                key_ascii  <= e.arg;
                @(posedge CLOCK_50);
                key_strobe <= 1'b0;
                @(posedge CLOCK_50);
                if (e.arg != 8'd0) m_irq = 1'b1;  // zero code leaves irq alone
            end
            2: begin
                irq_ack <= 1'b1;
                @(posedge CLOCK_50);
                irq_ack <= 1'b0;
                @(posedge CLOCK_50);
                m_irq = 1'b0;
            end
            3: begin
                repeat (soc_bus_pkg::SEC_BYTES) stream_byte();
                m_avail = 1'b1;
            end
            4: begin
                stream_byte();  // first byte of the next fill
                m_avail = 1'b0;
            end
            5: begin
                sd_ready <= e.arg[0];
                @(posedge CLOCK_50);
            end
            default: ;
        endcase
        off     = int'(e.req.addr) - int'(soc_bus_pkg::SEC_BASE);
        exp_val = e.exp;
        if (!e.req.wr && off >= 0 && off < soc_bus_pkg::SEC_BYTES) begin
            exp_val = 64'(rec[off]);  // sector window, one byte zero extended
        end
        if (e.req.wr && e.req.addr == soc_bus_pkg::SD_ADDR_ADDR) m_sector = e.req.wdata[31:0];
        while (!req_ready) @(posedge CLOCK_50);
        exp_name   <= e.name;
        exp_data   <= exp_val;
        exp_err    <= e.err;
        exp_irq    <= m_irq;
        exp_avail  <= m_avail;
        exp_sector <= m_sector;
        exp_start  <= e.req.wr && (e.req.addr == soc_bus_pkg::SD_READ_ADDR);
        req_valid  <= 1'b1;
        bus_req    <= e.req;
        @(posedge CLOCK_50);
        req_valid <= 1'b0;
        while (!done) @(posedge CLOCK_50);  // checker samples this same edge
    endtask

    // run limit, scaled from the table and one sector fill
    always @(posedge CLOCK_50) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, the bus never finished", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h53be_0172));
        KEY0 = 1'b0;
        req_valid = 1'b0;
        bus_req = '0;
        key_strobe = 1'b0;
        key_ascii = 8'd0;
        irq_ack = 1'b0;
        sd_byte_valid = 1'b0;
        sd_byte = 8'd0;
        sd_ready = 1'b0;
        exp_name = '0;
        exp_data = '0;
        exp_err = 1'b0;
        exp_irq = 1'b0;
        exp_avail = 1'b0;
        exp_sector = 32'd0;
        exp_start = 1'b0;
        m_irq = 1'b0;
        m_avail = 1'b0;
        m_sector = 32'd0;
        stream_idx = 0;

        // name, ev, arg, wr, size (0 b 1 h 2 w 3 d), addr, wdata, expected, err
        add_entry("st_w", 0, 0, 1, 2, 16'h0100, 64'h8765_4321, 64'h0, 0);
        add_entry("ld_b0", 0, 0, 0, 0, 16'h0100, 64'h0, 64'h8765_4321, 0);
        add_entry("ld_h1", 0, 0, 0, 1, 16'h0101, 64'h0, 64'h0087_6543, 0);  // shifted, not masked
        add_entry("ld_w2", 0, 0, 0, 2, 16'h0102, 64'h0, 64'h0000_8765, 0);
        add_entry("ld_b3", 0, 0, 0, 0, 16'h0103, 64'h0, 64'h0000_0087, 0);
        add_entry("st_b1", 0, 0, 1, 0, 16'h0101, 64'hAA, 64'h0, 0);
        add_entry("st_h2", 0, 0, 1, 1, 16'h0102, 64'h1234, 64'h0, 0);
        add_entry("ld_w0", 0, 0, 0, 2, 16'h0100, 64'h0, 64'h1234_AA21, 0);
        add_entry("st_d", 0, 0, 1, 3, 16'h0200, 64'h0123_4567_89AB_CDEF, 64'h0, 0);
        add_entry("ld_d", 0, 0, 0, 3, 16'h0200, 64'h0, 64'h0123_4567_89AB_CDEF, 0);
        add_entry("ld_hi_w", 0, 0, 0, 2, 16'h0204, 64'h0, 64'h0123_4567, 0);
        add_entry("avail_0", 0, 0, 0, 2, 16'h3020, 64'h0, 64'h0, 0);
        add_entry("fill", 3, 0, 0, 2, 16'h3020, 64'h0, 64'h1, 0);
        add_entry("sec_000", 0, 0, 0, 0, 16'h2000, 64'h0, 64'h0, 0);
        add_entry("sec_1ff", 0, 0, 0, 0, 16'h21FF, 64'h0, 64'h0, 0);
        add_entry("sec_0a5", 0, 0, 0, 1, 16'h20A5, 64'h0, 64'h0, 0);
        add_entry("refill", 4, 0, 0, 2, 16'h3020, 64'h0, 64'h0, 0);
        add_entry("key_41", 1, 8'h41, 0, 2, 16'h3000, 64'h0, 64'h41, 0);
        add_entry("key_ack", 2, 0, 0, 2, 16'h3000, 64'h0, 64'h41, 0);
        add_entry("key_00", 1, 8'h00, 0, 2, 16'h3000, 64'h0, 64'h0, 0);
        add_entry("sect_wr", 0, 0, 1, 2, 16'h3008, 64'hCAFE_0042, 64'h0, 0);
        add_entry("rd_start", 0, 0, 1, 2, 16'h3010, 64'h1, 64'h0, 0);
        add_entry("rdy_1", 5, 1, 0, 2, 16'h3018, 64'h0, 64'h1, 0);
        add_entry("rdy_0", 5, 0, 0, 2, 16'h3018, 64'h0, 64'h0, 0);
        add_entry("unmap_ld", 0, 0, 0, 2, 16'h1000, 64'h0, 64'h0, 1);
        add_entry("unmap_st", 0, 0, 1, 2, 16'h4000, 64'h55, 64'h0, 1);
        limit = 20 * (tbl.size() + 2 * soc_bus_pkg::SEC_BYTES);

        repeat (16) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        @(posedge CLOCK_50);
        foreach (tbl[i]) run_entry(tbl[i]);
        repeat (4) @(posedge CLOCK_50);  // let a late stray pulse show up

        $display("errors: %0d over %0d entries", check_errors, tbl.size());
        if (check_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: build.f
hw/soc_bus_pkg.sv
hw/bus_sequencer.sv
hw/sector_counter.sv
hw/word_ram.sv
hw/sector_buffer.sv
hw/io_regs.sv
hw/soc_bus_top.sv
tests/soc_bus_asserts.sv
tests/bus_checker.sv
tests/tb_soc_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile with verilator, run, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_soc_bus -f build.f -o tb_soc_bus \
    && ./obj_dir/tb_soc_bus | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
